//--- src/hwpe_regfile_pkg.sv
// Control register file definitions
package hwpe_regfile_pkg;

  typedef logic [31:0] data_t;    // One register word
  typedef logic [3:0]  be_t;      // Byte enables of a word
  typedef logic [3:0]  reg_idx_t; // Register index inside a context window
  typedef logic [7:0]  job_id_t;  // Job identifier

  // Register map, low address field
  localparam reg_idx_t REG_TRIGGER     = 4'd0; // Write queues the offload job
  localparam reg_idx_t REG_ACQUIRE     = 4'd1; // Read is test-and-set
  localparam reg_idx_t REG_FINISHED    = 4'd2; // Done count, clear on read
  localparam reg_idx_t REG_STATUS      = 4'd3; // One byte per context
  localparam reg_idx_t REG_RUNNING_JOB = 4'd4; // Id of the job in the engine

  // Indexes 5 to 7 are reserved
  localparam reg_idx_t JOB_BASE = 4'd8; // First job parameter word

  // Read responses
  localparam data_t RESP_ALL_CXT_BUSY = 32'hFFFF_FFFF;
  localparam data_t UNKNOWN_RDATA     = 32'hDEAD_BEEF;

  // FINISHED saturates here
  localparam int unsigned FINISHED_MAX = 2;

endpackage

//--- src/regfile_bus_if.sv
// Decoded register access
`timescale 1ns/1ps

interface regfile_bus_if
  import hwpe_regfile_pkg::*;
#(
  parameter int unsigned N_CONTEXT = 2
) ();

  localparam int unsigned CTX_W = (N_CONTEXT > 1) ? $clog2(N_CONTEXT) : 1;

  logic             req;   // Single-cycle strobe, always accepted
  logic             wen;   // 1 for write
  reg_idx_t         idx;
  logic [CTX_W-1:0] ctx;
  data_t            wdata;
  be_t              be;

  modport master (output req, wen, idx, ctx, wdata, be);
  modport slave  (input  req, wen, idx, ctx, wdata, be);

endinterface

//--- src/job_ctl_if.sv
// Job control events and context pointers
`timescale 1ns/1ps

interface job_ctl_if #(
  parameter int unsigned N_CONTEXT = 2
) ();

  localparam int unsigned CTX_W = (N_CONTEXT > 1) ? $clog2(N_CONTEXT) : 1;

  logic             trigger;     // Accepted trigger
  logic             done;        // Engine done while busy
  logic [CTX_W-1:0] pointer_ctx; // Context being offloaded
  logic [CTX_W-1:0] running_ctx; // Context in the engine

  modport tracker (output trigger, done, pointer_ctx, running_ctx);
  modport regs    (input  trigger, done, pointer_ctx, running_ctx);

endinterface

//--- src/regfile_decoder.sv
// Register file address decoder
`timescale 1ns/1ps

module regfile_decoder
  import hwpe_regfile_pkg::*;
#(
  parameter int unsigned N_CONTEXT = 2,
  parameter int unsigned N_IO_REGS = 4,
  localparam int unsigned CTX_W = (N_CONTEXT > 1) ? $clog2(N_CONTEXT) : 1,
  localparam int unsigned ADDR_W = $bits(reg_idx_t) + CTX_W
) (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              clear_i,
  input  logic              req_i,
  input  logic              wen_i,
  input  logic [ADDR_W-1:0] addr_i,
  input  data_t             wdata_i,
  input  be_t               be_i,
  input  logic              full_i,
  input  job_id_t           offload_id_i,
  input  data_t             store_rdata_i,
  input  data_t             mand_rdata_i,
  output logic              acquire_o,
  output logic              trigger_o,
  output data_t             rdata_o,
  regfile_bus_if.master     bus
);

  typedef enum logic [1:0] {
    SRC_RESP,  // Acquire response, unknown address or idle
    SRC_STORE, // Job parameter store
    SRC_MAND   // Mandatory registers
  } src_e;

  reg_idx_t         idx;
  logic [CTX_W-1:0] ctx;
  logic             rd_req;
  logic             job_hit;
  logic             mand_hit;
  src_e             r_src;
  data_t            r_resp;

  assign idx    = addr_i[$bits(reg_idx_t)-1:0];
  assign ctx    = addr_i[ADDR_W-1:$bits(reg_idx_t)];
  assign rd_req = req_i & ~wen_i;

  assign bus.req   = req_i;
  assign bus.wen   = wen_i;
  assign bus.idx   = idx;
  assign bus.ctx   = ctx;
  assign bus.wdata = wdata_i;
  assign bus.be    = be_i;

  assign acquire_o = rd_req && (idx == REG_ACQUIRE);
  assign trigger_o = req_i && wen_i && (idx == REG_TRIGGER);

  // Job window only exists for implemented contexts
  assign job_hit = (idx >= JOB_BASE) && (32'(idx) < 32'(JOB_BASE) + N_IO_REGS) &&
                   (32'(ctx) < N_CONTEXT);

  assign mand_hit = (idx == REG_FINISHED) || (idx == REG_STATUS) ||
                    (idx == REG_RUNNING_JOB);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_src  <= SRC_RESP;
      r_resp <= '0;
    end else if (clear_i) begin
      r_src  <= SRC_RESP;
      r_resp <= '0;
    end else if (rd_req) begin
      if (job_hit) begin
        r_src <= SRC_STORE;
      end else if (mand_hit) begin
        r_src <= SRC_MAND;
      end else begin
        r_src <= SRC_RESP;
        if (idx == REG_ACQUIRE) begin
          r_resp <= full_i ? RESP_ALL_CXT_BUSY : {24'b0, offload_id_i};
        end else begin
          r_resp <= UNKNOWN_RDATA; // Trigger read and reserved indexes
        end
      end
    end
  end

  // Second half of the read, one cycle after the request
  always_comb begin
    case (r_src)
      SRC_STORE: rdata_o = store_rdata_i;
      SRC_MAND:  rdata_o = mand_rdata_i;
      default:   rdata_o = r_resp;
    endcase
  end

endmodule

//--- src/job_param_store.sv
// Per-context job parameter storage
`timescale 1ns/1ps

module job_param_store
  import hwpe_regfile_pkg::*;
#(
  parameter int unsigned N_CONTEXT = 2,
  parameter int unsigned N_IO_REGS = 4,
  localparam int unsigned CTX_W = (N_CONTEXT > 1) ? $clog2(N_CONTEXT) : 1,
  localparam int unsigned WORD_W = (N_IO_REGS > 1) ? $clog2(N_IO_REGS) : 1
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    clear_i,
  input  logic [CTX_W-1:0]        running_ctx_i,
  output data_t                   rdata_o,
  output data_t [N_IO_REGS-1:0]   job_params_o,
  regfile_bus_if.slave            bus
);

  data_t [N_CONTEXT-1:0][N_IO_REGS-1:0] mem;

  reg_idx_t          word_off;
  logic [WORD_W-1:0] word;
  logic              hit;

  assign word_off = bus.idx - JOB_BASE;
  assign word     = word_off[WORD_W-1:0];

  assign hit = (bus.idx >= JOB_BASE) && (32'(bus.idx) < 32'(JOB_BASE) + N_IO_REGS) &&
               (32'(bus.ctx) < N_CONTEXT);

  // Byte-enable writes, cleared with the rest of the job state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem <= '0;
    end else if (clear_i) begin
      mem <= '0;
    end else if (bus.req && bus.wen && hit) begin
      for (int b = 0; b < $bits(be_t); b++) begin
        if (bus.be[b]) begin
          mem[bus.ctx][word][b*8 +: 8] <= bus.wdata[b*8 +: 8];
        end
      end
    end
  end

  // Registered read port, holds between reads
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (clear_i) begin
      rdata_o <= '0;
    end else if (bus.req && !bus.wen) begin
      rdata_o <= hit ? mem[bus.ctx][word] : '0;
    end
  end

  assign job_params_o = mem[running_ctx_i]; // Words seen by the engine

endmodule

//--- src/context_tracker.sv
// Job context tracker
`timescale 1ns/1ps

module context_tracker
  import hwpe_regfile_pkg::*;
#(
  parameter int unsigned N_CONTEXT = 2,
  localparam int unsigned CTX_W = (N_CONTEXT > 1) ? $clog2(N_CONTEXT) : 1,
  localparam int unsigned CNT_W = $clog2(N_CONTEXT + 1)
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             clear_i,
  input  logic             acquire_i,
  input  logic             trigger_i,
  input  logic             done_i,
  output logic             full_o,
  output job_id_t          offload_id_o,
  output logic             start_o,
  output logic             busy_o,
  output logic [CTX_W-1:0] running_ctx_o,
  job_ctl_if.tracker       ctl
);

  logic [CNT_W-1:0] cnt; // Queued plus running jobs
  logic [CTX_W-1:0] offload_ctx;
  logic [CTX_W-1:0] running_ctx;
  logic [CTX_W-1:0] offload_nxt;
  logic [CTX_W-1:0] running_nxt;
  logic             trig_ok;
  logic             done_ok;
  logic             start_d;

  assign full_o  = (cnt == CNT_W'(N_CONTEXT));
  assign trig_ok = trigger_i & ~full_o;  // Trigger when full is dropped
  assign done_ok = done_i & busy_o;

  // Pointers wrap at N_CONTEXT, which need not be a power of two
  assign offload_nxt = (offload_ctx == CTX_W'(N_CONTEXT - 1)) ? '0 : offload_ctx + 1'b1;
  assign running_nxt = (running_ctx == CTX_W'(N_CONTEXT - 1)) ? '0 : running_ctx + 1'b1;

  // Engine idle with a job waiting or arriving now
  assign start_d = ~busy_o & ((cnt != '0) | trig_ok);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt          <= '0;
      offload_ctx  <= '0;
      running_ctx  <= '0;
      offload_id_o <= '0;
      start_o      <= 1'b0;
      busy_o       <= 1'b0;
    end else if (clear_i) begin
      cnt          <= '0;
      offload_ctx  <= '0;
      running_ctx  <= '0;
      offload_id_o <= '0;
      start_o      <= 1'b0;
      busy_o       <= 1'b0;
    end else begin
      cnt <= cnt + CNT_W'(trig_ok) - CNT_W'(done_ok);
      if (trig_ok) begin
        offload_ctx <= offload_nxt;
      end
      if (done_ok) begin
        running_ctx <= running_nxt;
      end
      if (acquire_i && !full_o) begin
        offload_id_o <= offload_id_o + 1'b1; // Id handed out by this acquire
      end
      start_o <= start_d;
      busy_o  <= busy_o ? ~done_ok : start_d;
    end
  end

  assign running_ctx_o = running_ctx;

  assign ctl.trigger     = trig_ok;
  assign ctl.done        = done_ok;
  assign ctl.pointer_ctx = offload_ctx;
  assign ctl.running_ctx = running_ctx;

endmodule

//--- src/mandatory_regs.sv
// Status, running job and finished registers
`timescale 1ns/1ps

module mandatory_regs
  import hwpe_regfile_pkg::*;
#(
  parameter int unsigned N_CONTEXT = 2
) (
  input  logic         clk_i,
  input  logic         rst_ni,
  input  logic         clear_i,
  output data_t        rdata_o,
  regfile_bus_if.slave bus,
  job_ctl_if.regs      ctl
);

  logic [N_CONTEXT-1:0][7:0] r_status;
  data_t                     status_word;
  job_id_t                   r_running_id;
  logic                      r_running_incr;
  logic [1:0]                r_finished;
  logic                      rd_req;

  assign rd_req = bus.req & ~bus.wen;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_status       <= '0;
      r_running_id   <= '0;
      r_running_incr <= 1'b0;
      r_finished     <= '0;
    end else if (clear_i) begin
      r_status       <= '0;
      r_running_id   <= '0;
      r_running_incr <= 1'b0;
      r_finished     <= '0;
    end else begin
      for (int c = 0; c < N_CONTEXT; c++) begin
        if (ctl.trigger && (32'(ctl.pointer_ctx) == c)) begin
          r_status[c] <= 8'h01;
        end else if (ctl.done && (32'(ctl.running_ctx) == c)) begin
          r_status[c] <= 8'h00;
        end
      end
      r_running_incr <= ctl.done; // Job id follows done by one cycle
      if (r_running_incr) begin
        r_running_id <= r_running_id + 1'b1;
      end
      if (rd_req && (bus.idx == REG_FINISHED)) begin
        r_finished <= '0;
      end else if (ctl.done && (32'(r_finished) < FINISHED_MAX)) begin
        r_finished <= r_finished + 1'b1;
      end
    end
  end

  // Unused context bytes read as zero
  always_comb begin
    status_word = '0;
    status_word[N_CONTEXT*8-1:0] = r_status;
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_o <= '0;
    end else if (clear_i) begin
      rdata_o <= '0;
    end else if (rd_req) begin
      case (bus.idx)
        REG_STATUS:      rdata_o <= status_word;
        REG_RUNNING_JOB: rdata_o <= {24'b0, r_running_id};
        REG_FINISHED:    rdata_o <= {30'b0, r_finished}; // Value before the clear
        default:         rdata_o <= '0;
      endcase
    end
  end

endmodule

//--- src/hwpe_regfile_top.sv
// Engine control register file
`timescale 1ns/1ps

module hwpe_regfile_top
  import hwpe_regfile_pkg::*;
#(
  parameter int unsigned N_CONTEXT = 2,
  parameter int unsigned N_IO_REGS = 4,
  localparam int unsigned CTX_W = (N_CONTEXT > 1) ? $clog2(N_CONTEXT) : 1,
  localparam int unsigned ADDR_W = $bits(reg_idx_t) + CTX_W
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  req_i,
  input  logic                  wen_i,
  input  logic [ADDR_W-1:0]     addr_i,
  input  data_t                 wdata_i,
  input  be_t                   be_i,
  output data_t                 rdata_o,
  input  logic                  done_i,
  output logic                  start_o,
  output logic                  busy_o,
  output data_t [N_IO_REGS-1:0] job_params_o
);

  logic             acquire;
  logic             trigger;
  logic             full;
  job_id_t          offload_id;
  data_t            store_rdata;
  data_t            mand_rdata;
  logic [CTX_W-1:0] running_ctx;

  regfile_bus_if #(.N_CONTEXT(N_CONTEXT)) bus ();
  job_ctl_if     #(.N_CONTEXT(N_CONTEXT)) ctl ();

  regfile_decoder #(
    .N_CONTEXT(N_CONTEXT),
    .N_IO_REGS(N_IO_REGS)
  ) i_decoder (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
    .req_i(req_i), .wen_i(wen_i), .addr_i(addr_i), .wdata_i(wdata_i), .be_i(be_i),
    .full_i(full), .offload_id_i(offload_id),
    .store_rdata_i(store_rdata), .mand_rdata_i(mand_rdata),
    .acquire_o(acquire), .trigger_o(trigger), .rdata_o(rdata_o), .bus(bus)
  );

  job_param_store #(
    .N_CONTEXT(N_CONTEXT),
    .N_IO_REGS(N_IO_REGS)
  ) i_store (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i), .running_ctx_i(running_ctx),
    .rdata_o(store_rdata), .job_params_o(job_params_o), .bus(bus)
  );

  context_tracker #(.N_CONTEXT(N_CONTEXT)) i_tracker (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
    .acquire_i(acquire), .trigger_i(trigger), .done_i(done_i),
    .full_o(full), .offload_id_o(offload_id), .start_o(start_o), .busy_o(busy_o),
    .running_ctx_o(running_ctx), .ctl(ctl)
  );

  mandatory_regs #(.N_CONTEXT(N_CONTEXT)) i_mand (
    .clk_i(clk_i), .rst_ni(rst_ni), .clear_i(clear_i),
    .rdata_o(mand_rdata), .bus(bus), .ctl(ctl)
  );

endmodule

//--- verif/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int unsigned PERIOD_NS    = 40,
  parameter int unsigned RESET_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial clk_o = 1'b0;
  always #(PERIOD_NS / 2) clk_o = ~clk_o;

  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #1 rst_no = 1'b1; // Released just after an edge
  end

endmodule

//--- verif/hwpe_regfile_asserts.sv
// Register file control assertions
`timescale 1ns/1ps

module hwpe_regfile_asserts (
  input logic clk_i,
  input logic rst_ni,
  input logic start_i,
  input logic busy_i,
  input logic done_i
);

  // Engine start is a single pulse
  start_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni) start_i |=> !start_i)
    else $error("start_o stayed high for more than one cycle");

  done_busy: assert property (@(posedge clk_i) disable iff (!rst_ni) done_i |-> busy_i)
    else $error("done_i arrived while the engine was idle");

  reset_idle: assert property (@(posedge clk_i) !rst_ni |-> (!start_i && !busy_i))
    else $error("start_o or busy_o high during reset");

endmodule

bind hwpe_regfile_top hwpe_regfile_asserts i_asserts (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .start_i(start_o),
  .busy_i (busy_o),
  .done_i (done_i)
);

//--- verif/tb_hwpe_regfile.sv
// Register file testbench
`timescale 1ns/1ps

module tb_hwpe_regfile
  import hwpe_regfile_pkg::*;
();

  localparam int unsigned N_CONTEXT = 2;
  localparam int unsigned N_IO_REGS = 4;
  localparam int unsigned CTX_W = (N_CONTEXT > 1) ? $clog2(N_CONTEXT) : 1;
  localparam int unsigned ADDR_W = $bits(reg_idx_t) + CTX_W;

  typedef data_t [N_IO_REGS-1:0] params_t;
  typedef enum logic [2:0] {OP_WRITE, OP_READ, OP_DONE, OP_CLEAR, OP_WAIT} op_e;
  typedef enum logic [1:0] {CHK_NONE, CHK_DATA, CHK_CTRL} chk_e;

  typedef struct packed {
    op_e               op;
    logic [ADDR_W-1:0] addr;
    data_t             data;
    be_t               be;
    chk_e              chk;
    data_t             exp_data;   // Expected read data
    logic              exp_start;
    logic              exp_busy;
    params_t           exp_params; // Words of the running context
  } row_t;

  logic              clk;
  logic              rst_n;
  logic              clear;
  logic              req;
  logic              wen;
  logic [ADDR_W-1:0] addr;
  data_t             wdata;
  be_t               be;
  data_t             rdata;
  logic              done;
  logic              start;
  logic              busy;
  params_t           job_params;

  row_t        rows[$];
  params_t     model [N_CONTEXT]; // Expected parameter storage
  integer      seed = 32'hf8e8_3cb7;
  int unsigned cycles = 0;
  int unsigned cycle_limit = 0;

  tb_clk_gen i_clk (.clk_o(clk), .rst_no(rst_n));

  hwpe_regfile_top #(
    .N_CONTEXT(N_CONTEXT),
    .N_IO_REGS(N_IO_REGS)
  ) dut (
    .clk_i(clk), .rst_ni(rst_n), .clear_i(clear),
    .req_i(req), .wen_i(wen), .addr_i(addr), .wdata_i(wdata), .be_i(be),
    .rdata_o(rdata), .done_i(done), .start_o(start), .busy_o(busy),
    .job_params_o(job_params)
  );

  task automatic report_failure(string msg);
    $display("%s", msg);
    $display("** FAIL **");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic data_check(string name, data_t got, data_t exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  task automatic params_check(params_t got, params_t exp);
    for (int w = 0; w < N_IO_REGS; w++) begin
      if (got[w] !== exp[w]) begin
        report_failure($sformatf("FAIL job_params_o[%0d]: got 0x%h, expected 0x%h",
                                 w, got[w], exp[w]));
      end
    end
  endtask

  task automatic bit_check(string name, logic got, logic exp);
    if (got !== exp) begin
      report_failure($sformatf("FAIL %s: got 0x%h, expected 0x%h", name, got, exp));
    end
  endtask

  function automatic logic [ADDR_W-1:0] make_addr(int ctx, reg_idx_t idx);
    logic [CTX_W-1:0] c;
    c = CTX_W'(ctx);
    return {c, idx}; // Context sits above the register index
  endfunction

  task automatic add_row(op_e op, int ctx, reg_idx_t idx, data_t data, be_t be_v,
                         chk_e chk, data_t exp_data, logic exp_start, logic exp_busy,
                         int run_ctx);
    row_t r;
    r            = '0;
    r.op         = op;
    r.addr       = make_addr(ctx, idx);
    r.data       = data;
    r.be         = be_v;
    r.chk        = chk;
    r.exp_data   = exp_data;
    r.exp_start  = exp_start;
    r.exp_busy   = exp_busy;
    r.exp_params = model[run_ctx];
    rows.push_back(r);
  endtask

  // Byte-merged update of the expected storage
  task automatic write_row(int ctx, reg_idx_t idx, data_t data, be_t be_v);
    int w;
    if (idx >= JOB_BASE && int'(idx) < int'(JOB_BASE) + int'(N_IO_REGS)) begin
      w = int'(idx) - int'(JOB_BASE);
      for (int b = 0; b < 4; b++) begin
        if (be_v[b]) model[ctx][w][b*8 +: 8] = data[b*8 +: 8];
      end
    end
    add_row(OP_WRITE, ctx, idx, data, be_v, CHK_NONE, '0, 1'b0, 1'b0, 0);
  endtask

  task automatic read_row(int ctx, reg_idx_t idx, data_t exp);
    add_row(OP_READ, ctx, idx, '0, '0, CHK_DATA, exp, 1'b0, 1'b0, 0);
  endtask

  task automatic trigger_row(logic exp_start, logic exp_busy, int run_ctx);
    add_row(OP_WRITE, 0, REG_TRIGGER, '0, 4'hf, CHK_CTRL, '0, exp_start, exp_busy, run_ctx);
  endtask

  task automatic done_row(int run_ctx);
    add_row(OP_DONE, 0, '0, '0, '0, CHK_CTRL, '0, 1'b0, 1'b0, run_ctx); // Engine goes idle
  endtask

  task automatic start_row(int run_ctx);
    add_row(OP_WAIT, 0, '0, '0, '0, CHK_CTRL, '0, 1'b1, 1'b1, run_ctx);
  endtask

  task automatic clear_row();
    foreach (model[c]) model[c] = '0;
    add_row(OP_CLEAR, 0, '0, '0, '0, CHK_CTRL, '0, 1'b0, 1'b0, 0);
  endtask

  task automatic build_table();
    foreach (model[c]) model[c] = '0;
    // Job parameters, full then partial writes
    for (int c = 0; c < N_CONTEXT; c++) begin
      for (int w = 0; w < N_IO_REGS; w++) begin
        write_row(c, reg_idx_t'(int'(JOB_BASE) + w), data_t'($random(seed)), 4'hf);
      end
    end
    write_row(0, reg_idx_t'(int'(JOB_BASE) + 1), data_t'($random(seed)), 4'b0101);
    write_row(1, reg_idx_t'(int'(JOB_BASE) + 3), data_t'($random(seed)), 4'b1000);
    write_row(1, JOB_BASE, data_t'($random(seed)), 4'b0110);
    for (int c = 0; c < N_CONTEXT; c++) begin
      for (int w = 0; w < N_IO_REGS; w++) begin
        read_row(c, reg_idx_t'(int'(JOB_BASE) + w), model[c][w]);
      end
    end
    read_row(0, 4'd5, UNKNOWN_RDATA);
    read_row(0, 4'd6, UNKNOWN_RDATA);
    read_row(0, 4'd7, UNKNOWN_RDATA);
    read_row(1, reg_idx_t'(int'(JOB_BASE) + int'(N_IO_REGS)), UNKNOWN_RDATA);
    // Acquire and trigger until every context is taken
    read_row(0, REG_ACQUIRE, 32'd0);
    trigger_row(1'b1, 1'b1, 0);
    read_row(0, REG_STATUS, 32'h0000_0001);
    read_row(0, REG_ACQUIRE, 32'd1);
    trigger_row(1'b0, 1'b1, 0);     // Queued behind the running job
    read_row(0, REG_STATUS, 32'h0000_0101);
    read_row(0, REG_ACQUIRE, RESP_ALL_CXT_BUSY);
    trigger_row(1'b0, 1'b1, 0);     // Full, so nothing changes
    read_row(0, REG_STATUS, 32'h0000_0101);
    read_row(0, REG_RUNNING_JOB, 32'd0);
    read_row(0, REG_FINISHED, 32'd0);
    done_row(1);
    start_row(1);                   // Queued context follows
    read_row(0, REG_STATUS, 32'h0000_0100);
    read_row(0, REG_RUNNING_JOB, 32'd1);
    read_row(0, REG_ACQUIRE, 32'd2);
    done_row(0);
    read_row(0, REG_STATUS, 32'd0);
    read_row(0, REG_FINISHED, 32'd2);
    read_row(0, REG_FINISHED, 32'd0);
    // Three more jobs saturate FINISHED
    trigger_row(1'b1, 1'b1, 0);
    done_row(1);
    trigger_row(1'b1, 1'b1, 1);
    read_row(0, REG_STATUS, 32'h0000_0100);
    done_row(0);
    trigger_row(1'b1, 1'b1, 0);
    done_row(1);
    read_row(0, REG_FINISHED, 32'd2);
    read_row(0, REG_FINISHED, 32'd0);
    read_row(0, REG_RUNNING_JOB, 32'd5);
    // Leave both pointers at context 1, FINISHED at 2 and both contexts busy
    trigger_row(1'b1, 1'b1, 1);
    done_row(0);
    trigger_row(1'b1, 1'b1, 0);
    done_row(1);
    trigger_row(1'b1, 1'b1, 1);
    trigger_row(1'b0, 1'b1, 1);
    read_row(0, REG_STATUS, 32'h0000_0101);
    // Clear brings everything back to zero
    clear_row();
    read_row(0, REG_STATUS, 32'd0);
    read_row(0, REG_RUNNING_JOB, 32'd0);
    read_row(0, REG_FINISHED, 32'd0);
    read_row(1, reg_idx_t'(int'(JOB_BASE) + 3), 32'd0);
    read_row(0, REG_ACQUIRE, 32'd0);
    write_row(0, reg_idx_t'(int'(JOB_BASE) + 2), data_t'($random(seed)), 4'hf);
    trigger_row(1'b1, 1'b1, 0);     // Pointers restart at context 0
    read_row(0, REG_STATUS, 32'h0000_0001);
    done_row(1);
  endtask

  task automatic apply_row(row_t r);
    @(posedge clk);
    #1;
    case (r.op)
      OP_WRITE, OP_READ: begin
        req   = 1'b1;
        wen   = (r.op == OP_WRITE);
        addr  = r.addr;
        wdata = r.data;
        be    = r.be;
      end
      OP_DONE:  done  = 1'b1;
      OP_CLEAR: clear = 1'b1;
      default: ;
    endcase
    if (r.op == OP_WAIT) begin
      while (!start) begin
        @(posedge clk);
        #1;
      end
    end else begin
      @(posedge clk);
      #1;
      req   = 1'b0;
      wen   = 1'b0;
      done  = 1'b0;
      clear = 1'b0;
    end
    case (r.chk)
      CHK_DATA: data_check("rdata_o", rdata, r.exp_data);
      CHK_CTRL: begin
        bit_check("start_o", start, r.exp_start);
        bit_check("busy_o", busy, r.exp_busy);
        params_check(job_params, r.exp_params);
      end
      default: ;
    endcase
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycle_limit != 0 && cycles >= cycle_limit) begin
      report_failure("timeout, the run took longer than the stimulus table allows");
    end
  end

  initial begin
    clear = 1'b0;
    req   = 1'b0;
    wen   = 1'b0;
    addr  = '0;
    wdata = '0;
    be    = '0;
    done  = 1'b0;
    build_table();
    cycle_limit = 2 * rows.size() + 100;
    wait (rst_n === 1'b1);
    foreach (rows[i]) apply_row(rows[i]);
    $display("** PASS **");
    $finish;
  end

endmodule

//--- verilog.f
src/hwpe_regfile_pkg.sv
src/regfile_bus_if.sv
src/job_ctl_if.sv
src/regfile_decoder.sv
src/job_param_store.sv
src/context_tracker.sv
src/mandatory_regs.sv
src/hwpe_regfile_top.sv
verif/tb_clk_gen.sv
verif/hwpe_regfile_asserts.sv
verif/tb_hwpe_regfile.sv

//--- Makefile
# Verilator build and run for the register file testbench

VERILATOR ?= verilator
TOP       ?= tb_hwpe_regfile
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?=

BIN     := $(BUILD_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv) $(wildcard verif/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	$(BIN) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
